// File: Makefile
TOP := core_tb
OBJ := obj_dir
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f compile.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) --Mdir $(OBJ) -f compile.f
	-./$(OBJ)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "Test OK" $(LOG) || (echo "Simulation ended without a verdict"; exit 1)

clean:
	rm -rf $(OBJ) $(LOG)

// File: compile.f
+incdir+source
source/core_pkg.sv
source/readback_if.sv
source/setting_reg.sv
source/wb_bus_fsm.sv
source/misc_ctrl.sv
source/vita_timer.sv
source/readback_mux.sv
source/core_top.sv
tests/tb_clock_gen.sv
tests/core_assert.sv
tests/core_tb.sv

// File: source/core_defines.svh
// Radio core shared constants
// Bus widths, settings address map and register reset values
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Wishbone and settings bus widths
`define CORE_DW 32
`define CORE_AW 16
`define SET_AW 8
`define RB_SEL_BIT 10

// Settings bus register bases
`define SR_MISC 0
`define SR_TIME64 192

// Misc register offsets
`define SR_CLOCK 0
`define SR_SERDES 1
`define SR_ADC 2
`define SR_LED_SW 3
`define SR_PHY 4
`define SR_LED_SRC 8

// Time register offsets
`define SR_TIME_HI 0
`define SR_TIME_LO 1
`define SR_TIME_CTRL 2

`define LED_SRC_RESET 8'h1E
`define COMPAT_NUM 4

`endif

// File: source/core_pkg.sv
// Radio core types
// Settings bus write and control register payloads
`include "core_defines.svh"

package core_pkg;

   // One settings bus write
   typedef struct packed {
      logic                stb;
      logic [`SET_AW-1:0]  addr;
      logic [`CORE_DW-1:0] data;
   } set_bus_t;

   // Clock generator control, register bits 4..0
   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
   } clock_ctrl_t;

   // Serdes control, register bits 3..0
   typedef struct packed {
      logic enable;
      logic prbsen;
      logic loopen;
      logic rx_en;
   } serdes_ctrl_t;

   // ADC output enables and power, register bits 3..0
   typedef struct packed {
      logic oe_a;
      logic on_a;
      logic oe_b;
      logic on_b;
   } adc_ctrl_t;

   typedef logic [7:0] led_t;

   typedef logic [63:0] vita_time_t;

   typedef logic [`CORE_DW-1:0] rb_word_t;

endpackage

// File: source/core_top.sv
// Radio core control and timing top level
// Wishbone slave, misc control registers, VITA time and readback bank
`timescale 1ns/1ns
`include "core_defines.svh"

module core_top (
   input  logic                    dsp_clk,
   input  logic                    arst_n_i,
   // Wishbone slave
   input  logic                    wb_cyc_i,
   input  logic                    wb_stb_i,
   input  logic                    wb_we_i,
   input  logic [`CORE_AW-1:0]     wb_adr_i,
   input  logic [`CORE_DW-1:0]     wb_dat_i,
   // Byte lanes ignored, all writes are full words
   input  logic [`CORE_DW/8-1:0]   wb_sel_i,
   output logic [`CORE_DW-1:0]     wb_dat_o,
   output logic                    wb_ack_o,
   // Timing and status
   input  logic                    pps_i,
   input  logic                    run_tx_i,
   input  logic                    run_rx_i,
   input  logic                    clk_status_i,
   input  logic                    serdes_link_up_i,
   input  logic                    sim_mode_i,
   input  logic [3:0]              clock_divider_i,
   // Control outputs
   output logic                    clock_ready_o,
   output logic [1:0]              clk_en_o,
   output logic [1:0]              clk_sel_o,
   output logic                    ser_enable_o,
   output logic                    ser_prbsen_o,
   output logic                    ser_loopen_o,
   output logic                    ser_rx_en_o,
   output logic                    adc_oe_a_o,
   output logic                    adc_on_a_o,
   output logic                    adc_oe_b_o,
   output logic                    adc_on_b_o,
   output logic                    phy_reset_n_o,
   output logic [7:0]              leds_o,
   output logic                    pps_int_o
);

   core_pkg::set_bus_t     set_bus;
   core_pkg::clock_ctrl_t  clock_ctrl;
   core_pkg::serdes_ctrl_t serdes_ctrl;
   core_pkg::adc_ctrl_t    adc_ctrl;
   core_pkg::vita_time_t   vita_time;
   core_pkg::vita_time_t   vita_time_pps;

   readback_if rb_if ();

   ////////////////////////////////////////////////////////////
   // Bus front end
   ////////////////////////////////////////////////////////////
   wb_bus_fsm i_wb_bus_fsm (
      .dsp_clk(dsp_clk), .arst_n_i(arst_n_i),
      .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
      .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i),
      .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
      .set_o(set_bus), .rb(rb_if.master));

   ////////////////////////////////////////////////////////////
   // Settings consumers
   ////////////////////////////////////////////////////////////
   misc_ctrl i_misc_ctrl (
      .dsp_clk(dsp_clk), .arst_n_i(arst_n_i), .set_i(set_bus),
      .run_tx_i(run_tx_i), .run_rx_i(run_rx_i),
      .clk_status_i(clk_status_i), .serdes_link_up_i(serdes_link_up_i),
      .clock_o(clock_ctrl), .serdes_o(serdes_ctrl), .adc_o(adc_ctrl),
      .phy_reset_n_o(phy_reset_n_o), .leds_o(leds_o));

   vita_timer #(.base(`SR_TIME64)) i_vita_timer (
      .dsp_clk(dsp_clk), .arst_n_i(arst_n_i), .set_i(set_bus), .pps_i(pps_i),
      .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps),
      .pps_int_o(pps_int_o));

   readback_mux i_readback_mux (
      .dsp_clk(dsp_clk), .arst_n_i(arst_n_i), .rb(rb_if.slave),
      .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps),
      .sim_mode_i(sim_mode_i), .clock_divider_i(clock_divider_i));

   // Control struct fields out to pins
   assign {clock_ready_o, clk_en_o, clk_sel_o} = clock_ctrl;
   assign {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} = serdes_ctrl;
   assign {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} = adc_ctrl;

endmodule

// File: source/misc_ctrl.sv
// Misc control registers
// Clock, serdes, ADC and PHY controls plus the LED source mux
`timescale 1ns/1ns
`include "core_defines.svh"

module misc_ctrl (
   input  logic                   dsp_clk,
   input  logic                   arst_n_i,
   input  core_pkg::set_bus_t     set_i,
   input  logic                   run_tx_i,
   input  logic                   run_rx_i,
   input  logic                   clk_status_i,
   input  logic                   serdes_link_up_i,
   output core_pkg::clock_ctrl_t  clock_o,
   output core_pkg::serdes_ctrl_t serdes_o,
   output core_pkg::adc_ctrl_t    adc_o,
   output logic                   phy_reset_n_o,
   output core_pkg::led_t         leds_o
);

   logic           phy_reset;
   core_pkg::led_t led_sw;
   core_pkg::led_t led_src;
   core_pkg::led_t led_hw;

   setting_reg #(.payload_t(core_pkg::clock_ctrl_t),
                 .my_addr(`SET_AW'(`SR_MISC + `SR_CLOCK))) i_sr_clock (
      .dsp_clk(dsp_clk), .arst_n_i(arst_n_i), .set_i(set_i),
      .out_o(clock_o), .changed_o());

   setting_reg #(.payload_t(core_pkg::serdes_ctrl_t),
                 .my_addr(`SET_AW'(`SR_MISC + `SR_SERDES))) i_sr_serdes (
      .dsp_clk(dsp_clk), .arst_n_i(arst_n_i), .set_i(set_i),
      .out_o(serdes_o), .changed_o());

   setting_reg #(.payload_t(core_pkg::adc_ctrl_t),
                 .my_addr(`SET_AW'(`SR_MISC + `SR_ADC))) i_sr_adc (
      .dsp_clk(dsp_clk), .arst_n_i(arst_n_i), .set_i(set_i),
      .out_o(adc_o), .changed_o());

   setting_reg #(.payload_t(logic),
                 .my_addr(`SET_AW'(`SR_MISC + `SR_PHY))) i_sr_phy (
      .dsp_clk(dsp_clk), .arst_n_i(arst_n_i), .set_i(set_i),
      .out_o(phy_reset), .changed_o());

   ////////////////////////////////////////////////////////////
   // LEDs
   ////////////////////////////////////////////////////////////
   setting_reg #(.payload_t(core_pkg::led_t),
                 .my_addr(`SET_AW'(`SR_MISC + `SR_LED_SW))) i_sr_led_sw (
      .dsp_clk(dsp_clk), .arst_n_i(arst_n_i), .set_i(set_i),
      .out_o(led_sw), .changed_o());

   // Source bit 1 picks hardware, 0 picks software
   setting_reg #(.payload_t(core_pkg::led_t),
                 .my_addr(`SET_AW'(`SR_MISC + `SR_LED_SRC)),
                 .at_reset(`LED_SRC_RESET)) i_sr_led_src (
      .dsp_clk(dsp_clk), .arst_n_i(arst_n_i), .set_i(set_i),
      .out_o(led_src), .changed_o());

   assign led_hw = {3'b000, run_tx_i, run_rx_i, clk_status_i, serdes_link_up_i, 1'b0};
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

   // Register holds the reset request, pin is active low
   assign phy_reset_n_o = ~phy_reset;

endmodule

// File: source/readback_if.sv
// Readback request channel
// Bus FSM asks for one word, the bank answers a cycle later
`timescale 1ns/1ns

interface readback_if;

   logic               req;
   logic [3:0]         adr;
   core_pkg::rb_word_t dat;
   logic               valid;

   // Bus side issues the request
   modport master (
      output req,
      output adr,
      input  dat,
      input  valid
   );

   // Readback bank returns registered data
   modport slave (
      input  req,
      input  adr,
      output dat,
      output valid
   );

endinterface

// File: source/readback_mux.sv
// Readback bank
// Registers one of sixteen status words per request
`timescale 1ns/1ns
`include "core_defines.svh"

module readback_mux (
   input  logic                 dsp_clk,
   input  logic                 arst_n_i,
   readback_if.slave            rb,
   input  core_pkg::vita_time_t vita_time_i,
   input  core_pkg::vita_time_t vita_time_pps_i,
   input  logic                 sim_mode_i,
   input  logic [3:0]           clock_divider_i
);

   core_pkg::rb_word_t word;

   // Word map, unlisted words read zero
   always_comb begin
      unique case (rb.adr)
         4'd9:    word = {sim_mode_i, 27'd0, clock_divider_i};
         4'd10:   word = vita_time_i[63:32];
         4'd11:   word = vita_time_i[31:0];
         4'd12:   word = `CORE_DW'(`COMPAT_NUM);
         4'd14:   word = vita_time_pps_i[63:32];
         4'd15:   word = vita_time_pps_i[31:0];
         default: word = '0;
      endcase
   end

   always_ff @(posedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rb.valid <= 1'b0;
      end else begin
         rb.valid <= rb.req;
      end
   end

   // Data only moves on a request
   always_ff @(posedge dsp_clk) begin
      if (rb.req) begin
         rb.dat <= word;
      end
   end

endmodule

// File: source/setting_reg.sv
// Settings bus register
// Loads the low bits of a matching write and flags the change
`timescale 1ns/1ns
`include "core_defines.svh"

module setting_reg #(
   parameter type                payload_t = logic [`CORE_DW-1:0],
   parameter logic [`SET_AW-1:0] my_addr   = '0,
   parameter payload_t           at_reset  = '0
) (
   input  logic               dsp_clk,
   input  logic               arst_n_i,
   input  core_pkg::set_bus_t set_i,
   output payload_t           out_o,
   output logic               changed_o
);

   localparam int unsigned PW = $bits(payload_t);

   logic hit;

   assign hit = set_i.stb && (set_i.addr == my_addr);

   always_ff @(posedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         out_o     <= at_reset;
         changed_o <= 1'b0;
      end else begin
         changed_o <= hit;
         if (hit) begin
            out_o <= payload_t'(set_i.data[PW-1:0]);
         end
      end
   end

endmodule

// File: source/vita_timer.sv
// VITA 64-bit time counter
// Free running count, loaded at once or on the next PPS edge
`timescale 1ns/1ns
`include "core_defines.svh"

module vita_timer #(
   parameter logic [`SET_AW-1:0] base = `SR_TIME64
) (
   input  logic                 dsp_clk,
   input  logic                 arst_n_i,
   input  core_pkg::set_bus_t   set_i,
   input  logic                 pps_i,
   output core_pkg::vita_time_t vita_time_o,
   output core_pkg::vita_time_t vita_time_pps_o,
   output logic                 pps_int_o
);

   core_pkg::rb_word_t   time_hi;
   core_pkg::rb_word_t   time_lo;
   logic                 ctrl_now;
   logic                 ctrl_changed;
   core_pkg::vita_time_t count_q;
   logic                 pending_q;
   logic                 pps_s1_q;
   logic                 pps_s2_q;
   logic                 pps_d3_q;
   logic                 load_now;

   setting_reg #(.payload_t(core_pkg::rb_word_t),
                 .my_addr(base + `SET_AW'(`SR_TIME_HI))) i_sr_time_hi (
      .dsp_clk(dsp_clk), .arst_n_i(arst_n_i), .set_i(set_i),
      .out_o(time_hi), .changed_o());

   setting_reg #(.payload_t(core_pkg::rb_word_t),
                 .my_addr(base + `SET_AW'(`SR_TIME_LO))) i_sr_time_lo (
      .dsp_clk(dsp_clk), .arst_n_i(arst_n_i), .set_i(set_i),
      .out_o(time_lo), .changed_o());

   // Bit 0 set means load now, clear means wait for PPS
   setting_reg #(.payload_t(logic),
                 .my_addr(base + `SET_AW'(`SR_TIME_CTRL))) i_sr_time_ctrl (
      .dsp_clk(dsp_clk), .arst_n_i(arst_n_i), .set_i(set_i),
      .out_o(ctrl_now), .changed_o(ctrl_changed));

   ////////////////////////////////////////////////////////////
   // PPS sync and edge detect
   ////////////////////////////////////////////////////////////
   always_ff @(posedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         pps_s1_q  <= 1'b0;
         pps_s2_q  <= 1'b0;
         pps_d3_q  <= 1'b0;
         pps_int_o <= 1'b0;
      end else begin
         pps_s1_q  <= pps_i;
         pps_s2_q  <= pps_s1_q;
         pps_d3_q  <= pps_s2_q;
         pps_int_o <= pps_s2_q & ~pps_d3_q;
      end
   end

   ////////////////////////////////////////////////////////////
   // Counter, pending load and capture
   ////////////////////////////////////////////////////////////
   assign load_now = (ctrl_changed & ctrl_now) | (pps_int_o & pending_q);

   // Loaded value shows in the load cycle, counting resumes from there
   assign vita_time_o = load_now ? {time_hi, time_lo} : count_q;

   always_ff @(posedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         count_q         <= '0;
         pending_q       <= 1'b0;
         vita_time_pps_o <= '0;
      end else begin
         count_q <= vita_time_o + 64'd1;
         if (ctrl_changed && !ctrl_now) begin
            pending_q <= 1'b1;
         end else if (pps_int_o) begin
            pending_q <= 1'b0;
         end
         if (pps_int_o) begin
            vita_time_pps_o <= vita_time_o;
         end
      end
   end

endmodule

// File: source/wb_bus_fsm.sv
// Wishbone classic slave FSM
// Writes to the low half become settings strobes, reads of the high half
// become readback requests
`timescale 1ns/1ns
`include "core_defines.svh"

module wb_bus_fsm (
   input  logic                dsp_clk,
   input  logic                arst_n_i,
   input  logic                wb_cyc_i,
   input  logic                wb_stb_i,
   input  logic                wb_we_i,
   input  logic [`CORE_AW-1:0] wb_adr_i,
   input  logic [`CORE_DW-1:0] wb_dat_i,
   output logic [`CORE_DW-1:0] wb_dat_o,
   output logic                wb_ack_o,
   output core_pkg::set_bus_t  set_o,
   readback_if.master          rb
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_WR_ACK,
      ST_RD_WAIT,
      ST_ACK
   } state_t;

   state_t                 state_q;
   logic [`RB_SEL_BIT:2]   adr_q;
   logic                   bus_live;
   logic                   rb_half;

   assign bus_live = wb_cyc_i & wb_stb_i;
   assign rb_half  = adr_q[`RB_SEL_BIT];

   ////////////////////////////////////////////////////////////
   // State register
   ////////////////////////////////////////////////////////////
   always_ff @(posedge dsp_clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= ST_IDLE;
      end else begin
         unique case (state_q)
            ST_IDLE: begin
               if (bus_live) begin
                  state_q <= wb_we_i ? ST_WR_ACK : ST_RD_WAIT;
               end
            end
            // Bank registers the word during this cycle
            ST_RD_WAIT: state_q <= ST_ACK;
            // Both ack states fall back to idle for one cycle
            default:    state_q <= ST_IDLE;
         endcase
      end
   end

   // Address held for the rest of the cycle
   always_ff @(posedge dsp_clk) begin
      if (state_q == ST_IDLE && bus_live) begin
         adr_q <= wb_adr_i[`RB_SEL_BIT:2];
      end
   end

   ////////////////////////////////////////////////////////////
   // Outputs
   ////////////////////////////////////////////////////////////
   // Fixed ack delay, one cycle for writes and two for reads
   assign wb_ack_o = (state_q == ST_WR_ACK) | (state_q == ST_ACK);

   // Master holds write data until ack, so the live bus feeds the strobe
   assign set_o = '{
      stb:  bus_live & (state_q == ST_WR_ACK) & ~rb_half,
      addr: adr_q[9:2],
      data: wb_dat_i
   };

   assign rb.req = (state_q == ST_RD_WAIT) & rb_half;
   assign rb.adr = adr_q[5:2];

   // Settings half never raises req, so valid stays low and reads zero
   assign wb_dat_o = (state_q == ST_ACK && rb.valid) ? rb.dat : '0;

endmodule

// File: tests/core_assert.sv
// Wishbone FSM protocol assertions
// Bound into every wb_bus_fsm instance
`timescale 1ns/1ns

module core_assert (
   input logic               dsp_clk,
   input logic               arst_n_i,
   input logic               wb_cyc_i,
   input logic               wb_stb_i,
   input logic               wb_we_i,
   input logic               wb_ack_o,
   input core_pkg::set_bus_t set_i
);

   // Failures seen so far, read by the testbench at the end
   int unsigned fail_count = 0;

   ack_in_cycle: assert property (@(posedge dsp_clk) disable iff (!arst_n_i)
      wb_ack_o |-> (wb_cyc_i && wb_stb_i))
      else begin
         $error("ack raised outside an active bus cycle");
         fail_count++;
      end

   // One ack per access, never two in a row
   ack_single: assert property (@(posedge dsp_clk) disable iff (!arst_n_i)
      wb_ack_o |=> !wb_ack_o)
      else begin
         $error("ack held for more than one cycle");
         fail_count++;
      end

   strobe_on_write_ack: assert property (@(posedge dsp_clk) disable iff (!arst_n_i)
      set_i.stb |-> (wb_ack_o && wb_we_i))
      else begin
         $error("settings strobe without a write ack");
         fail_count++;
      end

endmodule

bind wb_bus_fsm core_assert i_core_assert (
   .dsp_clk(dsp_clk),
   .arst_n_i(arst_n_i),
   .wb_cyc_i(wb_cyc_i),
   .wb_stb_i(wb_stb_i),
   .wb_we_i(wb_we_i),
   .wb_ack_o(wb_ack_o),
   .set_i(set_o)
);

// File: tests/core_tb.sv
// Radio core control testbench
// Random register traffic, readback and VITA time checks against a model
`timescale 1ns/1ns
`include "core_defines.svh"

module core_tb;

   localparam int N_REG         = 40;
   localparam int N_LED         = 30;
   localparam int N_RB          = 12;
   localparam int PLANNED_OPS   = N_REG + N_LED + 6 * N_RB + 25;
   localparam int CYCLES_PER_OP = 200;
   localparam int ACK_LIMIT     = 16;

   logic dsp_clk, arst_n;
   logic wb_cyc, wb_stb, wb_we, pps, run_tx, run_rx, clk_status, link_up, sim_mode;
   logic [15:0] wb_adr;
   logic [31:0] wb_dat_w, wb_dat_r;
   logic [3:0]  wb_sel, clk_div;
   logic        wb_ack, clock_ready, ser_enable, ser_prbsen, ser_loopen, ser_rx_en;
   logic [1:0]  clk_en, clk_sel;
   logic        adc_oe_a, adc_on_a, adc_oe_b, adc_on_b, phy_reset_n, pps_int;
   logic [7:0]  leds;

   // Reference model state
   core_pkg::clock_ctrl_t  exp_clock   = '0;
   core_pkg::serdes_ctrl_t exp_serdes  = '0;
   core_pkg::adc_ctrl_t    exp_adc     = '0;
   logic                   exp_phy     = 1'b0;
   core_pkg::led_t         exp_led_sw  = '0;
   core_pkg::led_t         exp_led_src = 8'h1E;
   core_pkg::vita_time_t   exp_load    = '0;

   logic [31:0] rng_state = 32'd66;
   int unsigned mismatches   = 0;
   int unsigned other_errors = 0;

   tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(8)) i_clock_gen (
      .dsp_clk_o(dsp_clk), .arst_n_o(arst_n));

   core_top i_core_top (
      .dsp_clk(dsp_clk), .arst_n_i(arst_n),
      .wb_cyc_i(wb_cyc), .wb_stb_i(wb_stb), .wb_we_i(wb_we), .wb_adr_i(wb_adr),
      .wb_dat_i(wb_dat_w), .wb_sel_i(wb_sel), .wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack),
      .pps_i(pps), .run_tx_i(run_tx), .run_rx_i(run_rx), .clk_status_i(clk_status),
      .serdes_link_up_i(link_up), .sim_mode_i(sim_mode), .clock_divider_i(clk_div),
      .clock_ready_o(clock_ready), .clk_en_o(clk_en), .clk_sel_o(clk_sel),
      .ser_enable_o(ser_enable), .ser_prbsen_o(ser_prbsen), .ser_loopen_o(ser_loopen),
      .ser_rx_en_o(ser_rx_en), .adc_oe_a_o(adc_oe_a), .adc_on_a_o(adc_on_a),
      .adc_oe_b_o(adc_oe_b), .adc_on_b_o(adc_on_b), .phy_reset_n_o(phy_reset_n),
      .leds_o(leds), .pps_int_o(pps_int));

   function automatic logic [31:0] next_rand();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   function automatic logic [15:0] set_addr(input int unsigned ra);
      return 16'(ra << 2);
   endfunction

   function automatic logic [15:0] rb_addr(input int unsigned word);
      return 16'((1 << `RB_SEL_BIT) | (word << 2));
   endfunction

   // Register file as software sees it, low bits of each write
   function automatic void model_write(input int unsigned ra, input logic [31:0] d);
      case (ra)
         `SR_MISC + `SR_CLOCK:            exp_clock   = core_pkg::clock_ctrl_t'(d[4:0]);
         `SR_MISC + `SR_SERDES:           exp_serdes  = core_pkg::serdes_ctrl_t'(d[3:0]);
         `SR_MISC + `SR_ADC:              exp_adc     = core_pkg::adc_ctrl_t'(d[3:0]);
         `SR_MISC + `SR_PHY:              exp_phy     = d[0];
         `SR_MISC + `SR_LED_SW:           exp_led_sw  = d[7:0];
         `SR_MISC + `SR_LED_SRC:          exp_led_src = d[7:0];
         `SR_TIME64 + `SR_TIME_HI:        exp_load[63:32] = d;
         `SR_TIME64 + `SR_TIME_LO:        exp_load[31:0]  = d;
         default: ;
      endcase
   endfunction

   // Source bit 1 shows the status input, 0 the software bit
   function automatic core_pkg::led_t exp_leds();
      core_pkg::led_t hw;
      core_pkg::led_t led;
      hw    = '0;
      hw[4] = run_tx;
      hw[3] = run_rx;
      hw[2] = clk_status;
      hw[1] = link_up;
      for (int b = 0; b < 8; b++) begin
         led[b] = exp_led_src[b] ? hw[b] : exp_led_sw[b];
      end
      return led;
   endfunction

   ////////////////////////////////////////////////////////////
   // Bus and stimulus tasks
   ////////////////////////////////////////////////////////////
   task automatic bus_cycle(input logic we, input logic [15:0] adr,
                            input core_pkg::rb_word_t wdat, output core_pkg::rb_word_t rdat);
      int n;
      @(posedge dsp_clk);
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= we;
      wb_adr   <= adr;
      wb_dat_w <= wdat;
      n = 0;
      do begin
         @(negedge dsp_clk);
         n++;
      end while (!wb_ack && n < ACK_LIMIT);
      rdat = wb_dat_r;
      if (!wb_ack) begin
         other_errors++;
         $display("Bus timeout: no ack for access to address 0x%h", adr);
      end
      @(posedge dsp_clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   task automatic wb_write(input int unsigned ra, input logic [31:0] d);
      core_pkg::rb_word_t unused_rd;
      bus_cycle(1'b1, set_addr(ra), d, unused_rd);
      model_write(ra, d);
   endtask

   task automatic wb_read(input logic [15:0] adr, output core_pkg::rb_word_t rd);
      bus_cycle(1'b0, adr, '0, rd);
   endtask

   task automatic drive_status(input logic [31:0] v);
      @(posedge dsp_clk);
      run_tx     <= v[0];
      run_rx     <= v[1];
      clk_status <= v[2];
      link_up    <= v[3];
      sim_mode   <= v[4];
      clk_div    <= v[8:5];
   endtask

   ////////////////////////////////////////////////////////////
   // Compare tasks
   ////////////////////////////////////////////////////////////
   task automatic check_clock(input core_pkg::clock_ctrl_t got, input core_pkg::clock_ctrl_t exp);
      if (got !== exp) begin
         mismatches++;
         $display("Mismatch clock_ctrl: got 0x%h expected 0x%h", got, exp);
      end
   endtask

   task automatic check_serdes(input core_pkg::serdes_ctrl_t got,
                               input core_pkg::serdes_ctrl_t exp);
      if (got !== exp) begin
         mismatches++;
         $display("Mismatch serdes_ctrl: got 0x%h expected 0x%h", got, exp);
      end
   endtask

   task automatic check_adc(input core_pkg::adc_ctrl_t got, input core_pkg::adc_ctrl_t exp);
      if (got !== exp) begin
         mismatches++;
         $display("Mismatch adc_ctrl: got 0x%h expected 0x%h", got, exp);
      end
   endtask

   task automatic check_led(input core_pkg::led_t got, input core_pkg::led_t exp);
      if (got !== exp) begin
         mismatches++;
         $display("Mismatch leds_o: got 0x%h expected 0x%h", got, exp);
      end
   endtask

   task automatic check_word(input string name, input core_pkg::rb_word_t got,
                             input core_pkg::rb_word_t exp);
      if (got !== exp) begin
         mismatches++;
         $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
      end
   endtask

   task automatic check_time(input string name, input core_pkg::vita_time_t got,
                             input core_pkg::vita_time_t exp);
      if (got !== exp) begin
         mismatches++;
         $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
      end
   endtask

   // All misc outputs against the model, sampled mid cycle
   task automatic check_misc();
      @(negedge dsp_clk);
      check_clock(core_pkg::clock_ctrl_t'({clock_ready, clk_en, clk_sel}), exp_clock);
      check_serdes(core_pkg::serdes_ctrl_t'({ser_enable, ser_prbsen, ser_loopen, ser_rx_en}),
                   exp_serdes);
      check_adc(core_pkg::adc_ctrl_t'({adc_oe_a, adc_on_a, adc_oe_b, adc_on_b}), exp_adc);
      check_word("phy_reset_n_o", core_pkg::rb_word_t'(phy_reset_n),
                 core_pkg::rb_word_t'(!exp_phy));
      check_led(leds, exp_leds());
   endtask

   // Watchdog sized from the planned number of bus operations
   initial begin
      repeat (PLANNED_OPS * CYCLES_PER_OP) @(posedge dsp_clk);
      $display("Watchdog timeout: the run did not finish in time");
      $display("Test FAILED");
      $finish;
   end

   ////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////
   initial begin
      logic [31:0]          r;
      logic [31:0]          hi;
      logic [31:0]          lo;
      core_pkg::rb_word_t   v;
      core_pkg::rb_word_t   v2;
      core_pkg::rb_word_t   exp_w;
      core_pkg::vita_time_t t;
      int unsigned          ra;
      int unsigned          assert_fails;
      int                   n;
      {wb_cyc, wb_stb, wb_we, pps, run_tx, run_rx, clk_status, link_up, sim_mode} <= '0;
      wb_adr   <= '0;
      wb_dat_w <= '0;
      wb_sel   <= 4'hF;
      clk_div  <= '0;
      wait (arst_n === 1'b1);
      @(negedge dsp_clk);
      if (wb_ack !== 1'b0 || pps_int !== 1'b0) begin
         other_errors++;
         $display("Outputs not idle after reset: ack %b pps_int %b", wb_ack, pps_int);
      end
      check_misc();

      // Misc control registers, offset 5 is unmapped
      for (int i = 0; i < N_REG; i++) begin
         r = next_rand();
         case (r % 32'd5)
            0:       ra = `SR_MISC + `SR_CLOCK;
            1:       ra = `SR_MISC + `SR_SERDES;
            2:       ra = `SR_MISC + `SR_ADC;
            3:       ra = `SR_MISC + `SR_PHY;
            default: ra = `SR_MISC + 5;
         endcase
         wb_write(ra, next_rand());
         check_misc();
      end

      // LED mux, first with the reset source mask
      drive_status(next_rand());
      check_misc();
      for (int i = 0; i < N_LED; i++) begin
         r = next_rand();
         case (r % 32'd3)
            0:       wb_write(`SR_MISC + `SR_LED_SW, next_rand());
            1:       wb_write(`SR_MISC + `SR_LED_SRC, next_rand());
            default: drive_status(next_rand());
         endcase
         check_misc();
      end

      // Readback bank
      wb_read(rb_addr(12), v);
      check_word("word 12", v, `CORE_DW'(`COMPAT_NUM));
      for (int i = 0; i < N_RB; i++) begin
         drive_status(next_rand());
         wb_read(rb_addr(9), v);
         exp_w      = '0;
         exp_w[31]  = sim_mode;
         exp_w[3:0] = clk_div;
         check_word("word 9", v, exp_w);
      end
      for (int w = 0; w < 16; w++) begin
         if (w < 9 || w == 13) begin
            wb_read(rb_addr(w), v);
            check_word("unused readback word", v, '0);
         end
      end
      for (int i = 0; i < N_RB; i++) begin
         // Leave a nonzero word in the bank first
         wb_read(rb_addr(12), v);
         wb_read(set_addr(next_rand() % 32'd256), v);
         check_word("settings half read", v, '0);
      end
      // Readback half writes must not reach the settings bus
      for (int i = 0; i < N_RB; i++) begin
         r = next_rand() % 32'd10;
         ra = (r < 9) ? r : 13;
         bus_cycle(1'b1, rb_addr(ra), next_rand(), v);
         wb_read(rb_addr(ra), v);
         check_word("readback after write", v, '0);
      end
      check_misc();

      // Immediate time load
      hi = next_rand();
      lo = next_rand() & 32'h0FFF_FFFF;
      wb_write(`SR_TIME64 + `SR_TIME_HI, hi);
      wb_write(`SR_TIME64 + `SR_TIME_LO, lo);
      wb_write(`SR_TIME64 + `SR_TIME_CTRL, 32'd1);
      wb_read(rb_addr(10), v);
      check_word("time high", v, exp_load[63:32]);
      wb_read(rb_addr(11), v);
      wb_read(rb_addr(11), v2);
      if (v < exp_load[31:0] || v2 <= v) begin
         other_errors++;
         $display("Time low word did not count up from the load: 0x%h then 0x%h", v, v2);
      end

      // Load armed for the next PPS edge
      hi = next_rand();
      lo = next_rand() & 32'h0FFF_FFFF;
      wb_write(`SR_TIME64 + `SR_TIME_HI, hi);
      wb_write(`SR_TIME64 + `SR_TIME_LO, lo);
      wb_write(`SR_TIME64 + `SR_TIME_CTRL, 32'd0);
      @(posedge dsp_clk);
      pps <= 1'b1;
      n = 0;
      do begin
         @(negedge dsp_clk);
         n++;
      end while (!pps_int && n < ACK_LIMIT);
      if (!pps_int) begin
         other_errors++;
         $display("No PPS interrupt pulse after the PPS rise");
      end
      @(negedge dsp_clk);
      if (pps_int) begin
         other_errors++;
         $display("PPS interrupt pulse longer than one cycle");
      end
      @(posedge dsp_clk);
      pps <= 1'b0;
      wb_read(rb_addr(14), v);
      wb_read(rb_addr(15), v2);
      check_time("vita_time_pps", {v, v2}, exp_load);
      wb_read(rb_addr(10), v);
      wb_read(rb_addr(11), v2);
      t = {v, v2};
      if (t < exp_load) begin
         other_errors++;
         $display("Current time 0x%h is below the PPS load 0x%h", t, exp_load);
      end

      repeat (4) @(posedge dsp_clk);
      assert_fails = i_core_top.i_wb_bus_fsm.i_core_assert.fail_count;
      $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
               mismatches, other_errors, assert_fails);
      if (mismatches == 0 && other_errors == 0 && assert_fails == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

// File: tests/tb_clock_gen.sv
// Testbench clock and reset source
// Free running clock, reset held low for the first rising edges
`timescale 1ns/1ns

module tb_clock_gen #(
   parameter int PERIOD_NS    = 8,
   parameter int RESET_CYCLES = 8
) (
   output logic dsp_clk_o,
   output logic arst_n_o
);

   initial begin
      dsp_clk_o = 1'b0;
      forever begin
         #(PERIOD_NS / 2) dsp_clk_o = ~dsp_clk_o;
      end
   end

   // Release lands on a rising edge
   initial begin
      arst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge dsp_clk_o);
      arst_n_o <= 1'b1;
   end

endmodule
